//--- include/adc_readout_defs.svh
`ifndef ADC_READOUT_DEFS_SVH
`define ADC_READOUT_DEFS_SVH

// Number of ADC channels, one column of the frame per channel
`define ADC_CHANNELS 16

// Bits per ADC sample
`define ADC_SAMPLE_W 16

// Rows per frame, one row per conversion
`define ADC_ROWS 48

// Width of a row index, wide enough for ADC_ROWS
`define ADC_ROW_W 6

// Width of a column index, wide enough for ADC_CHANNELS
`define ADC_COL_W 4

// Output stream word width
`define ADC_WORD_W 32

// Credits the sender holds after reset.
// This matches the depth of the downstream FIFO.
`define ADC_OUT_CREDITS 4

`endif

//--- source/adc_readout_pkg.sv
`include "adc_readout_defs.svh"

package adc_readout_pkg;

    // One captured conversion, channel 0 sits in the low bits
    typedef struct packed {
        logic [`ADC_CHANNELS-1:0][`ADC_SAMPLE_W-1:0] sample;
    } adc_row_t;

    // Readout window, inclusive on both ends
    typedef struct packed {
        logic [`ADC_ROW_W-1:0] row_start;
        logic [`ADC_ROW_W-1:0] row_end;
        logic [`ADC_COL_W-1:0] col_start;
        logic [`ADC_COL_W-1:0] col_end;
    } window_t;

    // Word type codes, same values as the channel type codes of the older readout
    typedef enum logic [1:0] {
        tag_header = 2'd1,
        tag_sample = 2'd2,
        tag_footer = 2'd3
    } word_tag_t;

    // Frame number takes whatever is left of a marker word after tag and window
    typedef logic [`ADC_WORD_W-2-$bits(window_t)-1:0] frame_num_t;

    typedef struct packed {
        word_tag_t                 tag;
        logic [`ADC_ROW_W-1:0]     row;
        logic [`ADC_COL_W-1:0]     col;
        logic [`ADC_SAMPLE_W-1:0]  sample;
        logic [`ADC_WORD_W-2-`ADC_ROW_W-`ADC_COL_W-`ADC_SAMPLE_W-1:0] zero;
    } sample_word_t;

    typedef struct packed {
        word_tag_t  tag;
        frame_num_t frame_num;
        window_t    window;
    } marker_word_t;

    // The tag in the top two bits tells which view applies
    typedef union packed {
        sample_word_t sample_w;
        marker_word_t marker_w;
    } out_word_u;

endpackage

//--- source/adc_sample_capture.sv
`timescale 1ns/1ns
`include "adc_readout_defs.svh"

module adc_sample_capture (
    input  logic                                        CLK,
    input  logic                                        rst_n,
    input  logic                                        cnv_strobe,
    input  logic                                        sr_out,
    input  logic [`ADC_CHANNELS-1:0][`ADC_SAMPLE_W-1:0] adc_data,
    output logic                                        row_valid,
    output logic                                        row_first,
    output adc_readout_pkg::adc_row_t                   row
);

    // Strobe and row-0 marker travel together so the writer sees
    // one aligned record per conversion
    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            row_valid <= 1'b0;
            row_first <= 1'b0;
        end
        else
        begin
            row_valid <= cnv_strobe;
            row_first <= cnv_strobe & sr_out;
        end
    end

    // Sample register only loads on a strobe, so the row stays put between conversions
    always_ff @(posedge CLK)
    begin
        if (cnv_strobe)
        begin
            row.sample <= adc_data;
        end
    end

endmodule

//--- source/row_writer.sv
`timescale 1ns/1ns
`include "adc_readout_defs.svh"

module row_writer (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  row_valid,
    input  logic                  row_first,
    input  logic                  busy,
    output logic                  wr_en,
    output logic                  wr_bank,
    output logic [`ADC_ROW_W-1:0] wr_row,
    output logic                  frame_ready,
    output logic                  ready_bank
);

    logic [`ADC_ROW_W-1:0] row_idx;
    logic                  synced;
    logic                  bank;
    logic                  last_row;

    // A row-0 marker always restarts the count, whatever the current index
    assign wr_row   = row_first ? '0 : row_idx;
    assign wr_en    = row_valid & (synced | row_first);
    assign wr_bank  = bank;
    assign last_row = (wr_row == `ADC_ROW_W'(`ADC_ROWS - 1));

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            row_idx     <= '0;
            synced      <= 1'b0;
            bank        <= 1'b0;
            frame_ready <= 1'b0;
            ready_bank  <= 1'b0;
        end
        else
        begin
            frame_ready <= 1'b0;
            if (wr_en)
            begin
                synced <= 1'b1;
                if (last_row)
                begin
                    row_idx <= '0;
                    // Reader still on the other bank, so this frame is lost
                    // and the same bank gets refilled
                    if (!busy)
                    begin
                        frame_ready <= 1'b1;
                        ready_bank  <= bank;
                        bank        <= ~bank;
                    end
                end
                else
                begin
                    row_idx <= wr_row + 1'b1;
                end
            end
        end
    end

endmodule

//--- source/frame_buffer.sv
`timescale 1ns/1ns
`include "adc_readout_defs.svh"

module frame_buffer (
    input  logic                      CLK,
    input  logic                      wr_en,
    input  logic                      wr_bank,
    input  logic [`ADC_ROW_W-1:0]     wr_row,
    input  adc_readout_pkg::adc_row_t wr_data,
    input  logic                      rd_bank,
    input  logic [`ADC_ROW_W-1:0]     rd_row,
    output adc_readout_pkg::adc_row_t rd_data
);
    import adc_readout_pkg::*;

    // Ping-pong storage, one full frame per bank
    adc_row_t mem [2][`ADC_ROWS];

    always_ff @(posedge CLK)
    begin
        if (wr_en)
        begin
            mem[wr_bank][wr_row] <= wr_data;
        end
    end

    // Registered read, data shows up the cycle after the address
    always_ff @(posedge CLK)
    begin
        rd_data <= mem[rd_bank][rd_row];
    end

endmodule

//--- source/window_reader.sv
`timescale 1ns/1ns
`include "adc_readout_defs.svh"

module window_reader (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic                       frame_ready,
    input  logic                       ready_bank,
    input  adc_readout_pkg::window_t   window,
    input  logic                       take,
    input  adc_readout_pkg::adc_row_t  rd_data,
    output logic                       busy,
    output logic                       rd_bank,
    output logic [`ADC_ROW_W-1:0]      rd_row,
    output adc_readout_pkg::out_word_u next_word,
    output logic                       next_valid,
    output logic                       next_last
);
    import adc_readout_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_header,
        st_fetch,
        st_samples,
        st_footer
    } state_t;

    state_t                state;
    window_t               win;
    frame_num_t            frame_num;
    logic [`ADC_ROW_W-1:0] row;
    logic [`ADC_COL_W-1:0] col;
    logic                  empty_win;

    // A reversed range in either direction leaves nothing to send but the markers
    assign empty_win = (win.row_start > win.row_end) || (win.col_start > win.col_end);
    assign busy      = (state != st_idle);
    assign rd_row    = row;

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= st_idle;
            win       <= '0;
            frame_num <= '0;
            row       <= '0;
            col       <= '0;
            rd_bank   <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    // Window is sampled here and held for the whole frame
                    if (frame_ready)
                    begin
                        win     <= window;
                        rd_bank <= ready_bank;
                        state   <= st_header;
                    end
                end
                st_header:
                begin
                    if (take)
                    begin
                        row   <= win.row_start;
                        col   <= win.col_start;
                        state <= empty_win ? st_footer : st_fetch;
                    end
                end
                st_fetch:
                begin
                    // One cycle for the buffer read to land
                    state <= st_samples;
                end
                st_samples:
                begin
                    if (take)
                    begin
                        if (col != win.col_end)
                        begin
                            col <= col + 1'b1;
                        end
                        else if (row != win.row_end)
                        begin
                            row   <= row + 1'b1;
                            col   <= win.col_start;
                            state <= st_fetch;
                        end
                        else
                        begin
                            state <= st_footer;
                        end
                    end
                end
                st_footer:
                begin
                    if (take)
                    begin
                        frame_num <= frame_num + 1'b1;
                        state     <= st_idle;
                    end
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Word under construction, held steady until the credit port takes it
    always_comb
    begin
        next_word  = '0;
        next_valid = 1'b0;
        next_last  = 1'b0;
        case (state)
            st_header,
            st_footer:
            begin
                next_word.marker_w.tag       = (state == st_header) ? tag_header : tag_footer;
                next_word.marker_w.frame_num = frame_num;
                next_word.marker_w.window    = win;
                next_valid                   = 1'b1;
                next_last                    = (state == st_footer);
            end
            st_samples:
            begin
                next_word.sample_w.tag    = tag_sample;
                next_word.sample_w.row    = row;
                next_word.sample_w.col    = col;
                next_word.sample_w.sample = rd_data.sample[col];
                next_valid                = 1'b1;
            end
            default:
            begin
                next_valid = 1'b0;
            end
        endcase
    end

endmodule

//--- source/output_credit_port.sv
`timescale 1ns/1ns
`include "adc_readout_defs.svh"

module output_credit_port (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic [`ADC_WORD_W-1:0] next_word,
    input  logic                   next_valid,
    input  logic                   next_last,
    input  logic                   credit_return,
    output logic                   take,
    output logic [`ADC_WORD_W-1:0] word,
    output logic                   word_valid,
    output logic                   frame_end
);

    localparam int CREDIT_W = $clog2(`ADC_OUT_CREDITS + 1);

    logic [CREDIT_W-1:0] credits;

    assign take = next_valid && (credits != '0);

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            credits    <= CREDIT_W'(`ADC_OUT_CREDITS);
            word_valid <= 1'b0;
            frame_end  <= 1'b0;
        end
        else
        begin
            // Spend and refund in the same cycle cancel out
            case ({take, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            word_valid <= take;
            frame_end  <= take & next_last;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (take)
        begin
            word <= next_word;
        end
    end

endmodule

//--- source/adc_readout_top.sv
`timescale 1ns/1ns
`include "adc_readout_defs.svh"

module adc_readout_top (
    input  logic                                        CLK,
    input  logic                                        rst_n,
    input  logic                                        cnv_strobe,
    input  logic                                        sr_out,
    input  logic [`ADC_CHANNELS-1:0][`ADC_SAMPLE_W-1:0] adc_data,
    input  adc_readout_pkg::window_t                    window,
    input  logic                                        credit_return,
    output adc_readout_pkg::out_word_u                  word,
    output logic                                        word_valid,
    output logic                                        frame_end
);
    import adc_readout_pkg::*;

    logic                  row_valid;
    logic                  row_first;
    adc_row_t              row;
    logic                  wr_en;
    logic                  wr_bank;
    logic [`ADC_ROW_W-1:0] wr_row;
    logic                  frame_ready;
    logic                  ready_bank;
    logic                  busy;
    logic                  rd_bank;
    logic [`ADC_ROW_W-1:0] rd_row;
    adc_row_t              rd_data;
    out_word_u             next_word;
    logic                  next_valid;
    logic                  next_last;
    logic                  take;

    adc_sample_capture i_adc_sample_capture (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .cnv_strobe (cnv_strobe),
        .sr_out     (sr_out),
        .adc_data   (adc_data),
        .row_valid  (row_valid),
        .row_first  (row_first),
        .row        (row)
    );

    row_writer i_row_writer (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .row_valid   (row_valid),
        .row_first   (row_first),
        .busy        (busy),
        .wr_en       (wr_en),
        .wr_bank     (wr_bank),
        .wr_row      (wr_row),
        .frame_ready (frame_ready),
        .ready_bank  (ready_bank)
    );

    // Captured row goes straight into the buffer, the writer only steers it
    frame_buffer i_frame_buffer (
        .CLK     (CLK),
        .wr_en   (wr_en),
        .wr_bank (wr_bank),
        .wr_row  (wr_row),
        .wr_data (row),
        .rd_bank (rd_bank),
        .rd_row  (rd_row),
        .rd_data (rd_data)
    );

    window_reader i_window_reader (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .frame_ready (frame_ready),
        .ready_bank  (ready_bank),
        .window      (window),
        .take        (take),
        .rd_data     (rd_data),
        .busy        (busy),
        .rd_bank     (rd_bank),
        .rd_row      (rd_row),
        .next_word   (next_word),
        .next_valid  (next_valid),
        .next_last   (next_last)
    );

    output_credit_port i_output_credit_port (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .next_word     (next_word),
        .next_valid    (next_valid),
        .next_last     (next_last),
        .credit_return (credit_return),
        .take          (take),
        .word          (word),
        .word_valid    (word_valid),
        .frame_end     (frame_end)
    );

endmodule

//--- tb/adc_readout_model.svh
// Row tracking mirrors the sensor protocol: row 0 comes with sr_out
logic [`ADC_CHANNELS-1:0][`ADC_SAMPLE_W-1:0] cur_rows [`ADC_ROWS];
logic [`ADC_CHANNELS-1:0][`ADC_SAMPLE_W-1:0] done_rows [`ADC_ROWS];
int unsigned            model_idx;
bit                     model_synced;
bit                     decide_pending;
time                    decide_time;
bit                     footer_pending;
logic [9:0]             model_frame_num;
logic [`ADC_WORD_W-1:0] exp_q [$];
int unsigned            drops;

task automatic model_row(input bit first,
                         input logic [`ADC_CHANNELS-1:0][`ADC_SAMPLE_W-1:0] data);
    begin
        if (first)
        begin
            model_idx    = 0;
            model_synced = 1'b1;
        end
        if (model_synced)
        begin
            cur_rows[model_idx] = data;
            if (model_idx == `ADC_ROWS - 1)
            begin
                // Row 47 is written two edges after its strobe
                done_rows      = cur_rows;
                decide_pending = 1'b1;
                decide_time    = $time + 16;
                model_idx      = 0;
            end
            else
            begin
                model_idx++;
            end
        end
    end
endtask

// A frame is taken only if no accepted frame is still waiting for its footer
task automatic model_decide(input window_t w);
    begin
        if (footer_pending)
        begin
            drops++;
        end
        else
        begin
            exp_q.push_back({2'd1, model_frame_num, w});
            if (w.row_start <= w.row_end && w.col_start <= w.col_end)
            begin
                for (int r = int'(w.row_start); r <= int'(w.row_end); r++)
                begin
                    for (int c = int'(w.col_start); c <= int'(w.col_end); c++)
                    begin
                        exp_q.push_back({2'd2, 6'(r), 4'(c), done_rows[r][c], 4'b0});
                    end
                end
            end
            exp_q.push_back({2'd3, model_frame_num, w});
            footer_pending  = 1'b1;
            model_frame_num = model_frame_num + 10'd1;
        end
    end
endtask

//--- tb/tb_adc_readout.sv
`timescale 1ns/1ns
`include "adc_readout_defs.svh"

module tb_adc_readout;
    import adc_readout_pkg::*;

    localparam int  TEST_FRAMES = 14;
    localparam time LIMIT_NS    = TEST_FRAMES * (48 * 6 + 800) * 8 + 20000;

    logic                                        CLK;
    logic                                        rst_n;
    logic                                        cnv_strobe;
    logic                                        sr_out;
    logic [`ADC_CHANNELS-1:0][`ADC_SAMPLE_W-1:0] adc_data;
    window_t                                     window;
    logic                                        credit_return;
    out_word_u                                   word;
    logic                                        word_valid;
    logic                                        frame_end;

    int unsigned errors;
    int unsigned words_seen;
    int unsigned outstanding;
    bit          hold;
    time         due_q [$];

    `include "adc_readout_model.svh"

    adc_readout_top i_adc_readout_top (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .cnv_strobe    (cnv_strobe),
        .sr_out        (sr_out),
        .adc_data      (adc_data),
        .window        (window),
        .credit_return (credit_return),
        .word          (word),
        .word_valid    (word_valid),
        .frame_end     (frame_end)
    );

    always #4 CLK = ~CLK;

    // Output checker and downstream FIFO model
    always @(posedge CLK)
    begin
        logic [`ADC_WORD_W-1:0] exp;
        time                    due;
        if (rst_n && !word_valid)
        begin
            assert (!frame_end)
            else
            begin
                $display("ERROR t=%0t frame_end exp=0 got=%0b", $time, frame_end);
                errors++;
            end
        end
        if (rst_n && word_valid)
        begin
            words_seen++;
            outstanding++;
            assert (exp_q.size() != 0)
            else
            begin
                $display("Word %h at %0t arrived when no word was expected", word, $time);
                errors++;
            end
            if (exp_q.size() != 0)
            begin
                exp = exp_q.pop_front();
                assert (word == exp)
                else
                begin
                    $display("ERROR t=%0t word exp=%h got=%h", $time, exp, word);
                    errors++;
                end
                assert (frame_end == (exp[31:30] == 2'd3))
                else
                begin
                    $display("ERROR t=%0t frame_end exp=%0b got=%0b", $time,
                             exp[31:30] == 2'd3, frame_end);
                    errors++;
                end
                if (exp[31:30] == 2'd3)
                begin
                    footer_pending = 1'b0;
                end
            end
            due = $time + 8 * ($urandom % 6);
            if (due_q.size() != 0 && due <= due_q[$])
            begin
                due = due_q[$] + 8;
            end
            due_q.push_back(due);
            assert (outstanding <= `ADC_OUT_CREDITS)
            else
            begin
                $display("More words in flight than credits at %0t", $time);
                errors++;
            end
        end
        if (decide_pending && $time == decide_time)
        begin
            model_decide(window);
            decide_pending = 1'b0;
        end
        credit_return <= 1'b0;
        if (!hold && due_q.size() != 0 && due_q[0] <= $time)
        begin
            credit_return <= 1'b1;
            void'(due_q.pop_front());
            outstanding--;
        end
    end

    task automatic convert(input bit first);
        logic [`ADC_CHANNELS-1:0][`ADC_SAMPLE_W-1:0] data;
        int unsigned                                 gap;
        begin
            gap = 2 + ($urandom % 5);
            for (int ch = 0; ch < `ADC_CHANNELS; ch++)
            begin
                data[ch] = 16'($urandom);
            end
            @(posedge CLK);
            cnv_strobe <= 1'b1;
            sr_out     <= first;
            adc_data   <= data;
            model_row(first, data);
            @(posedge CLK);
            cnv_strobe <= 1'b0;
            sr_out     <= 1'b0;
            repeat (gap - 2) @(posedge CLK);
        end
    endtask

    task automatic send_frame();
        begin
            for (int i = 0; i < `ADC_ROWS; i++)
            begin
                convert(i == 0);
            end
        end
    endtask

    task automatic wait_drain();
        begin
            while (exp_q.size() != 0 || decide_pending || footer_pending)
            begin
                @(posedge CLK);
            end
            repeat (4) @(posedge CLK);
        end
    endtask

    task automatic set_window(input int rs, input int re, input int cs, input int ce);
        begin
            @(posedge CLK);
            window <= '{row_start: 6'(rs), row_end: 6'(re),
                        col_start: 4'(cs), col_end: 4'(ce)};
        end
    endtask

    task automatic report(input int num, input string name,
                          input int unsigned w0, input int unsigned e0);
        begin
            $display("test %0d %s: words=%0d errors=%0d", num, name,
                     words_seen - w0, errors - e0);
        end
    endtask

    initial
    begin
        #(LIMIT_NS);
        $display("Watchdog expired before the output stream finished");
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        int unsigned w0;
        int unsigned e0;
        int unsigned d0;
        int          a;
        int          b;
        void'($urandom(32'hc4f1));
        CLK             = 1'b0;
        rst_n           = 1'b0;
        cnv_strobe      = 1'b0;
        sr_out          = 1'b0;
        adc_data        = '0;
        window          = '0;
        credit_return   = 1'b0;
        hold            = 1'b0;
        model_frame_num = '0;
        repeat (3) @(posedge CLK);
        rst_n <= 1'b1;

        // Unsynchronized rows come first and must never show up
        w0 = words_seen;
        e0 = errors;
        set_window(0, 47, 0, 15);
        repeat (`ADC_ROWS) convert(1'b0);
        repeat (3)
        begin
            send_frame();
            wait_drain();
        end
        assert (words_seen - w0 == 3 * (`ADC_ROWS * `ADC_CHANNELS + 2))
        else
        begin
            $display("ERROR t=%0t words exp=%0d got=%0d", $time,
                     3 * (`ADC_ROWS * `ADC_CHANNELS + 2), words_seen - w0);
            errors++;
        end
        report(1, "full window", w0, e0);

        w0 = words_seen;
        e0 = errors;
        for (int f = 0; f < 2; f++)
        begin
            a = $urandom % 48;
            b = $urandom % 48;
            set_window(a < b ? a : b, a < b ? b : a, 0, 0);
            a = $urandom % 16;
            b = $urandom % 16;
            window.col_start <= 4'(a < b ? a : b);
            window.col_end   <= 4'(a < b ? b : a);
            send_frame();
            wait_drain();
        end
        set_window(40, 5, 3, 9);
        send_frame();
        wait_drain();
        report(2, "random windows", w0, e0);

        w0 = words_seen;
        e0 = errors;
        set_window(0, 47, 0, 15);
        hold <= 1'b1;
        send_frame();
        repeat (60) @(posedge CLK);
        assert (outstanding == `ADC_OUT_CREDITS)
        else
        begin
            $display("ERROR t=%0t outstanding exp=%0d got=%0d", $time,
                     `ADC_OUT_CREDITS, outstanding);
            errors++;
        end
        hold <= 1'b0;
        wait_drain();
        report(3, "credit stall", w0, e0);

        w0 = words_seen;
        e0 = errors;
        d0 = drops;
        hold <= 1'b1;
        repeat (3) send_frame();
        repeat (20) @(posedge CLK);
        hold <= 1'b0;
        wait_drain();
        assert (drops > d0)
        else
        begin
            $display("No frame was dropped while the reader was stalled");
            errors++;
        end
        report(4, "frame drop", w0, e0);

        // Restart in mid-frame throws the partial rows away
        w0 = words_seen;
        e0 = errors;
        convert(1'b1);
        repeat (19) convert(1'b0);
        send_frame();
        wait_drain();
        report(5, "mid-frame restart", w0, e0);

        $display("tests=5 words=%0d errors=%0d drops=%0d", words_seen, errors, drops);
        if (errors == 0)
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- adc_readout_top.f
+incdir+include
+incdir+tb
source/adc_readout_pkg.sv
source/adc_sample_capture.sv
source/row_writer.sv
source/frame_buffer.sv
source/window_reader.sv
source/output_credit_port.sv
source/adc_readout_top.sv
tb/tb_adc_readout.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ADC readout testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f adc_readout_top.f \
    --top-module tb_adc_readout -o sim_tb \
    && ./obj_dir/sim_tb | grep -q "TEST OK" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
